// File: hdl/hazardPkg.sv
package hazardPkg;

    ////////////////////////////////////////////////////////////////////////////
    // Widths
    ////////////////////////////////////////////////////////////////////////////

    localparam int REG_W = 5;
    localparam int T_W   = 2;
    localparam int FWD_W = 2;

    ////////////////////////////////////////////////////////////////////////////
    // Opcodes and funct codes
    ////////////////////////////////////////////////////////////////////////////

    localparam logic [5:0] OP_RTYPE = 6'b000000;
    localparam logic [5:0] OP_ORI   = 6'b001101;
    localparam logic [5:0] OP_LUI   = 6'b001111;
    localparam logic [5:0] OP_SW    = 6'b101011;
    localparam logic [5:0] OP_LW    = 6'b100011;
    localparam logic [5:0] OP_BEQ   = 6'b000100;
    localparam logic [5:0] OP_JAL   = 6'b000011;
    localparam logic [5:0] OP_J     = 6'b000010;

    // Only meaningful under OP_RTYPE
    localparam logic [5:0] FN_ADD = 6'b100000;
    localparam logic [5:0] FN_SUB = 6'b100010;
    localparam logic [5:0] FN_SWC = 6'b100001;
    localparam logic [5:0] FN_JR  = 6'b001000;

    // Link register written by jal
    localparam logic [REG_W-1:0] REG_RA = 5'd31;

    // Decode-stage forwarding selects
    localparam logic [FWD_W-1:0] FWD_NONE = 2'd0;
    localparam logic [FWD_W-1:0] FWD_E    = 2'd1;
    localparam logic [FWD_W-1:0] FWD_M    = 2'd2;

    ////////////////////////////////////////////////////////////////////////////
    // Instruction word, R-format and I-format views of the same bits
    ////////////////////////////////////////////////////////////////////////////

    typedef union packed {
        struct packed {
            logic [5:0]       op;
            logic [REG_W-1:0] rs;
            logic [REG_W-1:0] rt;
            logic [REG_W-1:0] rd;
            logic [4:0]       shamt;
            logic [5:0]       funct;
        } rView;
        struct packed {
            logic [5:0]       op;
            logic [REG_W-1:0] rs;
            logic [REG_W-1:0] rt;
            logic [15:0]      imm;
        } iView;
    } instrWord_u;

endpackage

// File: hdl/hazardIfs.sv
`timescale 1ns/100ps

// Source registers of the decode-stage instruction and when each is needed
interface useIf;
    import hazardPkg::*;

    logic [REG_W-1:0] rsNum;
    logic [REG_W-1:0] rtNum;
    logic [T_W-1:0]   tuseRs;
    logic [T_W-1:0]   tuseRt;

    modport dec (output rsNum, rtNum, tuseRs, tuseRt);
    modport chk (input  rsNum, rtNum, tuseRs, tuseRt);

endinterface

// Destinations of the instructions in execute and memory, with cycles to ready
interface prodIf;
    import hazardPkg::*;

    logic [REG_W-1:0] numE;
    logic [REG_W-1:0] numM;
    logic [T_W-1:0]   tnewE;
    logic [T_W-1:0]   tnewM;

    modport trk (output numE, numM, tnewE, tnewM);
    modport chk (input  numE, numM, tnewE, tnewM);

endinterface

// File: hdl/useDecoder.sv
`timescale 1ns/100ps

module useDecoder (
    input  hazardPkg::instrWord_u instr,
    useIf.dec                     srcUse
);
    import hazardPkg::*;

    logic [5:0]       op;
    logic [5:0]       funct;
    logic [REG_W-1:0] rs;
    logic [REG_W-1:0] rt;

    logic             rsRead;
    logic             rtRead;
    logic [T_W-1:0]   rsTuse;
    logic [T_W-1:0]   rtTuse;

    // Opcode and sources from the I view, funct from the R view
    assign op    = instr.iView.op;
    assign rs    = instr.iView.rs;
    assign rt    = instr.iView.rt;
    assign funct = instr.rView.funct;

    ////////////////////////////////////////////////////////////////////////////
    // Which sources are read, and how many cycles before they are needed
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        rsRead = 1'b0;
        rtRead = 1'b0;
        rsTuse = '0;
        rtTuse = '0;
        case (op)
            OP_RTYPE: begin
                case (funct)
                    FN_ADD, FN_SUB, FN_SWC: begin
                        rsRead = 1'b1;
                        rtRead = 1'b1;
                        rsTuse = T_W'(1);
                        rtTuse = T_W'(1);
                    end
                    // Jump target is needed in decode
                    FN_JR: rsRead = 1'b1;
                    default: ;
                endcase
            end
            OP_ORI, OP_LW: begin
                rsRead = 1'b1;
                rsTuse = T_W'(1);
            end
            OP_SW: begin
                rsRead = 1'b1;
                rtRead = 1'b1;
                rsTuse = T_W'(1);
                // Store data not needed until memory stage
                rtTuse = T_W'(2);
            end
            // Compare happens in decode
            OP_BEQ: begin
                rsRead = 1'b1;
                rtRead = 1'b1;
            end
            default: ;
        endcase
    end

    // Unread sources show up as r0
    assign srcUse.rsNum  = rsRead ? rs : '0;
    assign srcUse.rtNum  = rtRead ? rt : '0;
    assign srcUse.tuseRs = rsTuse;
    assign srcUse.tuseRt = rtTuse;

endmodule

// File: hdl/newTracker.sv
`timescale 1ns/100ps

module newTracker (
    input  logic                  clk,
    input  logic                  arstN,
    input  hazardPkg::instrWord_u instrE,
    prodIf.trk                    prod
);
    import hazardPkg::*;

    logic [5:0]       op;
    logic [5:0]       funct;
    logic [REG_W-1:0] rt;
    logic [REG_W-1:0] rd;

    logic [REG_W-1:0] numE;
    logic [T_W-1:0]   tnewE;
    logic [REG_W-1:0] numMQ;
    logic [T_W-1:0]   tnewMQ;
    logic [T_W-1:0]   tnewNext;

    assign op    = instrE.iView.op;
    assign rt    = instrE.iView.rt;
    assign funct = instrE.rView.funct;
    assign rd    = instrE.rView.rd;

    ////////////////////////////////////////////////////////////////////////////
    // Execute-stage destination and Tnew
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        numE  = '0;
        tnewE = '0;
        case (op)
            OP_RTYPE: begin
                if (funct == FN_ADD || funct == FN_SUB || funct == FN_SWC) begin
                    numE  = rd;
                    tnewE = T_W'(1);
                end
            end
            OP_ORI, OP_LUI: begin
                numE  = rt;
                tnewE = T_W'(1);
            end
            // Load data only exists after memory
            OP_LW: begin
                numE  = rt;
                tnewE = T_W'(2);
            end
            // Link address is ready in execute already
            OP_JAL: numE = REG_RA;
            default: ;
        endcase
    end

    ////////////////////////////////////////////////////////////////////////////
    // Memory-stage copy
    ////////////////////////////////////////////////////////////////////////////

    // One cycle closer to ready, floor at zero
    assign tnewNext = (tnewE == '0) ? '0 : tnewE - 1'b1;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            numMQ  <= '0;
            tnewMQ <= '0;
        end else begin
            numMQ  <= numE;
            tnewMQ <= tnewNext;
        end
    end

    assign prod.numE  = numE;
    assign prod.tnewE = tnewE;
    assign prod.numM  = numMQ;
    assign prod.tnewM = tnewMQ;

    // Longest producer is lw, so memory never waits more than one cycle
    tnewMBound: assert property (@(posedge clk) disable iff (!arstN)
        tnewMQ <= T_W'(1));

endmodule

// File: hdl/forwardSelect.sv
`timescale 1ns/100ps

module forwardSelect (
    useIf.chk                        srcUse,
    prodIf.chk                       prod,
    input  logic                     regWriteE,
    input  logic                     regWriteM,
    output logic [hazardPkg::FWD_W-1:0] fwdRs,
    output logic [hazardPkg::FWD_W-1:0] fwdRt,
    output logic                     matchRsE,
    output logic                     matchRsM,
    output logic                     matchRtE,
    output logic                     matchRtM
);
    import hazardPkg::*;

    // Nearest ready producer wins
    function automatic logic [FWD_W-1:0] pickFwd(
        input logic           hitE,
        input logic           hitM,
        input logic [T_W-1:0] tnE,
        input logic [T_W-1:0] tnM
    );
        logic [FWD_W-1:0] sel;
        sel = FWD_NONE;
        if (hitE && tnE == '0) begin
            sel = FWD_E;
        end else if (hitM && tnM == '0) begin
            sel = FWD_M;
        end
        return sel;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Producer matches
    ////////////////////////////////////////////////////////////////////////////

    // r0 is never a real dependency
    assign matchRsE = (srcUse.rsNum == prod.numE) && (srcUse.rsNum != '0) && regWriteE;
    assign matchRsM = (srcUse.rsNum == prod.numM) && (srcUse.rsNum != '0) && regWriteM;
    assign matchRtE = (srcUse.rtNum == prod.numE) && (srcUse.rtNum != '0) && regWriteE;
    assign matchRtM = (srcUse.rtNum == prod.numM) && (srcUse.rtNum != '0) && regWriteM;

    ////////////////////////////////////////////////////////////////////////////
    // Decode-stage selects
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        fwdRs = pickFwd(matchRsE, matchRsM, prod.tnewE, prod.tnewM);
        fwdRt = pickFwd(matchRtE, matchRtM, prod.tnewE, prod.tnewM);
    end

endmodule

// File: hdl/hazardCtrl.sv
`timescale 1ns/100ps

module hazardCtrl (
    useIf.chk     srcUse,
    prodIf.chk    prod,
    input  logic  matchRsE,
    input  logic  matchRsM,
    input  logic  matchRtE,
    input  logic  matchRtM,
    output logic  pcWrite,
    output logic  ifIdEn,
    output logic  idExClr
);
    import hazardPkg::*;

    logic stallRsE;
    logic stallRsM;
    logic stallRtE;
    logic stallRtM;
    logic stall;

    ////////////////////////////////////////////////////////////////////////////
    // Tuse against Tnew
    ////////////////////////////////////////////////////////////////////////////

    // Value needed sooner than the producer can supply it
    assign stallRsE = matchRsE && (srcUse.tuseRs < prod.tnewE);
    assign stallRsM = matchRsM && (srcUse.tuseRs < prod.tnewM);
    assign stallRtE = matchRtE && (srcUse.tuseRt < prod.tnewE);
    assign stallRtM = matchRtM && (srcUse.tuseRt < prod.tnewM);

    assign stall = stallRsE || stallRsM || stallRtE || stallRtM;

    ////////////////////////////////////////////////////////////////////////////
    // Pipeline enables
    ////////////////////////////////////////////////////////////////////////////

    // Freeze fetch and decode, bubble into execute
    always_comb begin
        pcWrite = !stall;
        ifIdEn  = !stall;
        idExClr = stall;
    end

    // A bubble while fetch still advances would drop an instruction
    always_comb begin
        noAdvanceOnBubble: assert (!(pcWrite && idExClr))
            else $error("pc advances while execute takes a bubble");
    end

endmodule

// File: hdl/hazardUnit.sv
`timescale 1ns/100ps

module hazardUnit (
    input  logic                        clk,
    input  logic                        arstN,
    input  logic [31:0]                 instrD,
    input  logic [31:0]                 instrE,
    input  logic                        regWriteE,
    input  logic                        regWriteM,
    output logic                        pcWrite,
    output logic                        ifIdEn,
    output logic                        idExClr,
    output logic [hazardPkg::FWD_W-1:0] fwdRs,
    output logic [hazardPkg::FWD_W-1:0] fwdRt
);

    logic matchRsE;
    logic matchRsM;
    logic matchRtE;
    logic matchRtM;

    useIf  useBus ();
    prodIf prodBus ();

    // Consumer side
    useDecoder uUseDecoder (
        .instr  (instrD),
        .srcUse (useBus.dec)
    );

    // Producer side
    newTracker uNewTracker (
        .clk    (clk),
        .arstN  (arstN),
        .instrE (instrE),
        .prod   (prodBus.trk)
    );

    forwardSelect uForwardSelect (
        .srcUse    (useBus.chk),
        .prod      (prodBus.chk),
        .regWriteE (regWriteE),
        .regWriteM (regWriteM),
        .fwdRs     (fwdRs),
        .fwdRt     (fwdRt),
        .matchRsE  (matchRsE),
        .matchRsM  (matchRsM),
        .matchRtE  (matchRtE),
        .matchRtM  (matchRtM)
    );

    hazardCtrl uHazardCtrl (
        .srcUse   (useBus.chk),
        .prod     (prodBus.chk),
        .matchRsE (matchRsE),
        .matchRsM (matchRsM),
        .matchRtE (matchRtE),
        .matchRtM (matchRtM),
        .pcWrite  (pcWrite),
        .ifIdEn   (ifIdEn),
        .idExClr  (idExClr)
    );

endmodule

// File: testbench/tbHazardUnit.sv
`timescale 1ns/100ps

module tbHazardUnit;
    import hazardPkg::*;

    localparam int CLK_PERIOD      = 10;
    localparam int RESET_CYCLES    = 4;
    localparam int DIRECTED_CYCLES = 8;
    localparam int RAND_CYCLES     = 200;
    localparam int TOTAL_CYCLES    = RESET_CYCLES + 1 + DIRECTED_CYCLES + RAND_CYCLES;

    logic             clk;
    logic             arstN;
    instrWord_u       instrD;
    instrWord_u       instrE;
    logic             regWriteE;
    logic             regWriteM;
    logic             pcWrite;
    logic             ifIdEn;
    logic             idExClr;
    logic [FWD_W-1:0] fwdRs;
    logic [FWD_W-1:0] fwdRt;

    // Reference copy of the memory stage
    logic [REG_W-1:0] refNumM;
    logic [T_W-1:0]   refTnewM;

    int     errors;
    int     checks;
    integer seed;

    hazardUnit u_dut (
        .clk       (clk),
        .arstN     (arstN),
        .instrD    (instrD),
        .instrE    (instrE),
        .regWriteE (regWriteE),
        .regWriteM (regWriteM),
        .pcWrite   (pcWrite),
        .ifIdEn    (ifIdEn),
        .idExClr   (idExClr),
        .fwdRs     (fwdRs),
        .fwdRt     (fwdRt)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    ////////////////////////////////////////////////////////////////////////////
    // Instruction encoders
    ////////////////////////////////////////////////////////////////////////////

    function automatic instrWord_u rInstr(input logic [5:0] fn, input int rs, input int rt,
                                          input int rd);
        instrWord_u w;
        w.rView.op    = OP_RTYPE;
        w.rView.rs    = REG_W'(rs);
        w.rView.rt    = REG_W'(rt);
        w.rView.rd    = REG_W'(rd);
        w.rView.shamt = 5'd0;
        w.rView.funct = fn;
        return w;
    endfunction

    function automatic instrWord_u iInstr(input logic [5:0] op, input int rs, input int rt);
        instrWord_u w;
        w.iView.op  = op;
        w.iView.rs  = REG_W'(rs);
        w.iView.rt  = REG_W'(rt);
        w.iView.imm = 16'h0024;
        return w;
    endfunction

    // Jump target overlays the rs and rt fields
    function automatic instrWord_u jInstr(input logic [5:0] op, input logic [25:0] target);
        instrWord_u w;
        w = {op, target};
        return w;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////////////////////////////////////////

    task automatic refUse(input instrWord_u w, output logic [REG_W-1:0] rsN,
                          output logic [REG_W-1:0] rtN, output logic [T_W-1:0] tuRs,
                          output logic [T_W-1:0] tuRt);
        logic [5:0] op;
        logic [5:0] fn;
        op   = w.iView.op;
        fn   = w.rView.funct;
        rsN  = '0;
        rtN  = '0;
        tuRs = '0;
        tuRt = '0;
        if (op == OP_RTYPE && (fn == FN_ADD || fn == FN_SUB || fn == FN_SWC)) begin
            rsN  = w.iView.rs;
            rtN  = w.iView.rt;
            tuRs = 2'd1;
            tuRt = 2'd1;
        end else if (op == OP_RTYPE && fn == FN_JR) begin
            rsN = w.iView.rs;
        end else if (op == OP_ORI || op == OP_LW) begin
            rsN  = w.iView.rs;
            tuRs = 2'd1;
        end else if (op == OP_SW) begin
            rsN  = w.iView.rs;
            rtN  = w.iView.rt;
            tuRs = 2'd1;
            tuRt = 2'd2;
        end else if (op == OP_BEQ) begin
            rsN = w.iView.rs;
            rtN = w.iView.rt;
        end
    endtask

    task automatic refProd(input instrWord_u w, output logic [REG_W-1:0] num,
                           output logic [T_W-1:0] tnew);
        logic [5:0] op;
        logic [5:0] fn;
        op   = w.iView.op;
        fn   = w.rView.funct;
        num  = '0;
        tnew = '0;
        if (op == OP_RTYPE && (fn == FN_ADD || fn == FN_SUB || fn == FN_SWC)) begin
            num  = w.rView.rd;
            tnew = 2'd1;
        end else if (op == OP_ORI || op == OP_LUI) begin
            num  = w.iView.rt;
            tnew = 2'd1;
        end else if (op == OP_LW) begin
            num  = w.iView.rt;
            tnew = 2'd2;
        end else if (op == OP_JAL) begin
            num = REG_RA;
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Compare tasks
    ////////////////////////////////////////////////////////////////////////////

    // Ordered as {pcWrite, ifIdEn, idExClr}
    task automatic checkCtrl(input string name, input logic [2:0] exp, input logic [2:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("FAILED %s: expected pcWrite/ifIdEn/idExClr %b, actual %b", name, exp, act);
        end
    endtask

    task automatic checkFwd(input string name, input logic [FWD_W-1:0] exp,
                            input logic [FWD_W-1:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("FAILED %s: expected select %0d, actual %0d", name, exp, act);
        end
    endtask

    // All five outputs against the model
    task automatic checkModel(input string name);
        logic [REG_W-1:0] rsN;
        logic [REG_W-1:0] rtN;
        logic [REG_W-1:0] numE;
        logic [T_W-1:0]   tuRs;
        logic [T_W-1:0]   tuRt;
        logic [T_W-1:0]   tnE;
        logic             hRsE;
        logic             hRsM;
        logic             hRtE;
        logic             hRtM;
        logic             stall;
        logic [FWD_W-1:0] expRs;
        logic [FWD_W-1:0] expRt;
        refUse(instrD, rsN, rtN, tuRs, tuRt);
        refProd(instrE, numE, tnE);
        hRsE  = (rsN != 0) && (rsN == numE) && regWriteE;
        hRsM  = (rsN != 0) && (rsN == refNumM) && regWriteM;
        hRtE  = (rtN != 0) && (rtN == numE) && regWriteE;
        hRtM  = (rtN != 0) && (rtN == refNumM) && regWriteM;
        stall = (hRsE && tuRs < tnE) || (hRsM && tuRs < refTnewM) ||
                (hRtE && tuRt < tnE) || (hRtM && tuRt < refTnewM);
        expRs = (hRsE && tnE == 0) ? FWD_E : ((hRsM && refTnewM == 0) ? FWD_M : FWD_NONE);
        expRt = (hRtE && tnE == 0) ? FWD_E : ((hRtM && refTnewM == 0) ? FWD_M : FWD_NONE);
        checkCtrl(name, {!stall, !stall, stall}, {pcWrite, ifIdEn, idExClr});
        checkFwd({name, " rs"}, expRs, fwdRs);
        checkFwd({name, " rt"}, expRt, fwdRt);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////////////////////////////////////////

    // Memory stage takes the old execute instruction before new inputs go in
    task automatic step(input instrWord_u d, input instrWord_u e, input logic wE,
                        input logic wM);
        logic [REG_W-1:0] n;
        logic [T_W-1:0]   t;
        @(posedge clk);
        refProd(instrE, n, t);
        if (!arstN) begin
            refNumM  = '0;
            refTnewM = '0;
        end else begin
            refNumM  = n;
            refTnewM = (t == '0) ? '0 : t - T_W'(1);
        end
        instrD    <= d;
        instrE    <= e;
        regWriteE <= wE;
        regWriteM <= wM;
        @(negedge clk);
    endtask

    task automatic resetDut();
        refNumM  = '0;
        refTnewM = '0;
        repeat (RESET_CYCLES) begin
            @(posedge clk);
            @(negedge clk);
            checkCtrl("reset held", 3'b110, {pcWrite, ifIdEn, idExClr});
            checkFwd("reset held rs", FWD_NONE, fwdRs);
            checkFwd("reset held rt", FWD_NONE, fwdRt);
        end
        @(posedge clk);
        arstN <= 1'b1;
        @(negedge clk);
        checkCtrl("reset released", 3'b110, {pcWrite, ifIdEn, idExClr});
        checkFwd("reset released rs", FWD_NONE, fwdRs);
        checkFwd("reset released rt", FWD_NONE, fwdRt);
    endtask

    task automatic testLoadUse();
        step(rInstr(FN_ADD, 1, 5, 6), iInstr(OP_LW, 2, 5), 1'b1, 1'b0);
        checkCtrl("load-use add", 3'b001, {pcWrite, ifIdEn, idExClr});
        checkModel("load-use add");
        // Store data is needed two cycles later
        step(iInstr(OP_SW, 1, 5), iInstr(OP_LW, 2, 5), 1'b1, 1'b0);
        checkCtrl("load-use sw", 3'b110, {pcWrite, ifIdEn, idExClr});
        checkModel("load-use sw");
    endtask

    task automatic testAluBranch();
        step(iInstr(OP_BEQ, 3, 4), rInstr(FN_ADD, 1, 2, 3), 1'b1, 1'b0);
        checkCtrl("alu-branch stall", 3'b001, {pcWrite, ifIdEn, idExClr});
        checkModel("alu-branch stall");
        // Bubble in execute with the add now in memory
        step(iInstr(OP_BEQ, 3, 4), '0, 1'b0, 1'b1);
        checkCtrl("alu-branch go", 3'b110, {pcWrite, ifIdEn, idExClr});
        checkFwd("alu-branch go rs", FWD_M, fwdRs);
        checkModel("alu-branch go");
    endtask

    task automatic testJalForward();
        step(rInstr(FN_JR, 31, 0, 0), jInstr(OP_JAL, 26'h0000100), 1'b1, 1'b0);
        checkCtrl("jal-jr", 3'b110, {pcWrite, ifIdEn, idExClr});
        checkFwd("jal-jr rs", FWD_E, fwdRs);
        checkModel("jal-jr");
    endtask

    task automatic testSuppress();
        // Load into r0 would stall the add if r0 counted as a dependency
        step(rInstr(FN_ADD, 0, 0, 7), iInstr(OP_LW, 0, 0), 1'b1, 1'b1);
        checkCtrl("r0 source", 3'b110, {pcWrite, ifIdEn, idExClr});
        checkModel("r0 source");
        step(rInstr(FN_ADD, 5, 0, 7), iInstr(OP_LW, 1, 5), 1'b0, 1'b1);
        checkCtrl("execute write off", 3'b110, {pcWrite, ifIdEn, idExClr});
        checkModel("execute write off");
        // lw r5 sits in memory with Tnew 1
        step(iInstr(OP_BEQ, 5, 5), '0, 1'b0, 1'b0);
        checkCtrl("memory write off", 3'b110, {pcWrite, ifIdEn, idExClr});
        checkModel("memory write off");
    endtask

    function automatic instrWord_u randInstr();
        int          pick;
        int          rs;
        int          rt;
        int          rd;
        logic [31:0] raw;
        pick = {$random(seed)} % 12;
        rs   = {$random(seed)} % 4;
        rt   = {$random(seed)} % 4;
        rd   = {$random(seed)} % 4;
        raw  = $random(seed);
        case (pick)
            0:       return rInstr(FN_ADD, rs, rt, rd);
            1:       return rInstr(FN_SUB, rs, rt, rd);
            2:       return rInstr(FN_SWC, rs, rt, rd);
            3:       return rInstr(FN_JR, rs, 0, 0);
            4:       return iInstr(OP_ORI, rs, rt);
            5:       return iInstr(OP_LUI, 0, rt);
            6:       return iInstr(OP_SW, rs, rt);
            7:       return iInstr(OP_LW, rs, rt);
            8:       return iInstr(OP_BEQ, rs, rt);
            9:       return jInstr(OP_JAL, raw[25:0]);
            10:      return jInstr(OP_J, raw[25:0]);
            default: return {6'b111111, raw[25:0]};
        endcase
    endfunction

    task automatic testRandom(input int cycles);
        instrWord_u  d;
        instrWord_u  e;
        logic [31:0] flags;
        for (int i = 0; i < cycles; i++) begin
            d     = randInstr();
            e     = randInstr();
            flags = $random(seed);
            step(d, e, flags[0], flags[1]);
            checkModel($sformatf("random %0d", i));
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Main sequence and watchdog
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        clk       = 1'b0;
        arstN     <= 1'b0;
        instrD    <= '0;
        instrE    <= '0;
        regWriteE <= 1'b0;
        regWriteM <= 1'b0;
        errors    = 0;
        checks    = 0;
        seed      = 70575;
        resetDut();
        testLoadUse();
        testAluBranch();
        testJalForward();
        testSuppress();
        testRandom(RAND_CYCLES);
        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

    initial begin
        #(2 * TOTAL_CYCLES * CLK_PERIOD);
        $display("Watchdog expired: tests did not finish within %0d cycles", 2 * TOTAL_CYCLES);
        $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

// File: src.f
hdl/hazardPkg.sv
hdl/hazardIfs.sv
hdl/useDecoder.sv
hdl/newTracker.sv
hdl/forwardSelect.sv
hdl/hazardCtrl.sv
hdl/hazardUnit.sv
testbench/tbHazardUnit.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    := --binary --timing --assert -Wno-fatal
TOP       := tbHazardUnit
FILELIST  := src.f
OBJDIR    := obj_dir
SIM       := $(OBJDIR)/V$(TOP)
SOURCES   := $(shell cat $(FILELIST))

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

run: $(SIM)
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST RESULT: PASS"

clean:
	rm -rf $(OBJDIR)
